/* i2c_cfg_pkg.sv */
`default_nettype none

package i2c_cfg_pkg;

	localparam int I2C_DWIDTH  = 32;
	localparam int I2C_NACKW   = 4;
	localparam int MACIP_WIDTH = 80;             // 48 bit mac then 32 bit ip

	localparam logic [7:0] SW_ADDR_WR     = 8'hE8; // bus switch, write
	localparam logic [7:0] EEPROM_CHANNEL = 8'd8;  // switch channel byte of the eeprom

	// one i2c engine command
	typedef struct packed {
		logic                 stopbit;
		logic [I2C_NACKW-1:0] nack;
		logic [I2C_DWIDTH-1:0] data;  // [31:24] address byte, bit 24 is read
	} i2c_cmd_t;

	typedef struct packed {
		logic                  rxvalid;
		logic [I2C_DWIDTH-1:0] rxdata;
	} i2c_rsp_t;

	typedef struct packed {
		logic board;
		logic lmk_adc;
		logic dac;
		logic dac2;
	} init_done_t;

	typedef enum logic [2:0] {
		IDLE,
		ISSUE,
		WAIT_BUSY,
		WAIT_DONE,
		DONE
	} seq_state_t;

	localparam int BOARD_LEN = 13;
	localparam int LMK_LEN   = 4;
	localparam int DAC_LEN   = 3;
	localparam int DAC2_LEN  = 3;

	localparam int BOARD_IDXW = $clog2(BOARD_LEN);
	localparam int FMC_IDXW   = 2;               // device tables hold at most 4 entries

	// select eeprom channel, set word pointer, read 10 bytes, release switch
	localparam i2c_cmd_t BOARD_CMDS [BOARD_LEN] = '{
		'{1'b1, 4'd2, 32'hE808_0000},
		'{1'b1, 4'd2, 32'hA8C8_0000},            // pointer to mac/ip block
		'{1'b1, 4'd1, 32'hA900_0000},
		'{1'b1, 4'd1, 32'hA900_0000},
		'{1'b1, 4'd1, 32'hA900_0000},
		'{1'b1, 4'd1, 32'hA900_0000},
		'{1'b1, 4'd1, 32'hA900_0000},
		'{1'b1, 4'd1, 32'hA900_0000},            // last mac byte
		'{1'b1, 4'd1, 32'hA900_0000},
		'{1'b1, 4'd1, 32'hA900_0000},
		'{1'b1, 4'd1, 32'hA900_0000},
		'{1'b1, 4'd1, 32'hA900_0000},            // last ip byte
		'{1'b1, 4'd2, 32'hE800_0000}
	};

	// clock chip and adc on the first mezzanine
	localparam i2c_cmd_t LMK_CMDS [LMK_LEN] = '{
		'{1'b1, 4'd2, 32'hE802_0000},
		'{1'b1, 4'd4, 32'h5800_0090},
		'{1'b1, 4'd4, 32'h5801_4302},
		'{1'b1, 4'd4, 32'h5A00_0001}
	};

	localparam i2c_cmd_t DAC_CMDS [DAC_LEN] = '{
		'{1'b1, 4'd2, 32'hE802_0000},
		'{1'b1, 4'd4, 32'h5C02_0082},
		'{1'b1, 4'd4, 32'h5C03_A300}
	};

	// second dac sits behind the other switch channel
	localparam i2c_cmd_t DAC2_CMDS [DAC2_LEN] = '{
		'{1'b1, 4'd2, 32'hE804_0000},
		'{1'b1, 4'd4, 32'h5C02_0082},
		'{1'b1, 4'd4, 32'h5C03_A300}
	};

endpackage

`default_nettype wire

/* board_init_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module board_init_seq import i2c_cfg_pkg::*; (
	input  logic     clkcfg,
	input  logic     poweronreset,
	input  logic     busy,
	output i2c_cmd_t cmd,
	output logic     start,
	output logic     done
);

	seq_state_t            state;
	logic [BOARD_IDXW-1:0] idx;
	logic                  last_entry;

	assign last_entry = (idx == BOARD_IDXW'(BOARD_LEN - 1));

	assign cmd   = BOARD_CMDS[idx];
	assign start = (state == ISSUE);  // single cycle strobe
	assign done  = (state == DONE);

	always_ff @(posedge clkcfg) begin
		if (poweronreset) begin
			state <= IDLE;
			idx   <= '0;
		end else begin
			case (state)
				IDLE: begin
					state <= ISSUE;  // enabled once reset is released
				end
				ISSUE: begin
					state <= WAIT_BUSY;
				end
				WAIT_BUSY: begin
					if (busy) begin
						state <= WAIT_DONE;
					end
				end
				WAIT_DONE: begin
					// falling busy ends the entry
					if (!busy) begin
						if (last_entry) begin
							state <= DONE;
						end else begin
							idx   <= idx + 1'b1;
							state <= ISSUE;
						end
					end
				end
				DONE: begin
					state <= DONE;  // table plays once per reset
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// engine must be idle whenever a new command goes out
	a_start_idle: assert property (
		@(posedge clkcfg) disable iff (poweronreset)
		start |-> !busy
	);

endmodule

`default_nettype wire

/* fmc_init_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module fmc_init_seq import i2c_cfg_pkg::*; (
	input  logic       clkcfg,
	input  logic       poweronreset,
	input  logic       enable,
	input  logic       busy,
	output i2c_cmd_t   cmd,
	output logic       start,
	output logic [2:0] stage_done
);

	seq_state_t          state;
	logic [1:0]          stage;  // 0 lmk/adc, 1 dac, 2 dac2
	logic [FMC_IDXW-1:0] idx;
	logic                last_entry;

	// table select by stage
	always_comb begin
		case (stage)
			2'd0: begin
				cmd        = LMK_CMDS[idx];
				last_entry = (idx == FMC_IDXW'(LMK_LEN - 1));
			end
			2'd1: begin
				cmd        = DAC_CMDS[idx];
				last_entry = (idx == FMC_IDXW'(DAC_LEN - 1));
			end
			2'd2: begin
				cmd        = DAC2_CMDS[idx];
				last_entry = (idx == FMC_IDXW'(DAC2_LEN - 1));
			end
			default: begin
				cmd        = '0;
				last_entry = 1'b1;
			end
		endcase
	end

	assign start = (state == ISSUE);

	always_ff @(posedge clkcfg) begin
		if (poweronreset) begin
			state      <= IDLE;
			stage      <= 2'd0;
			idx        <= '0;
			stage_done <= 3'b000;
		end else begin
			case (state)
				IDLE: begin
					if (enable) begin
						state <= ISSUE;  // board table finished
					end
				end
				ISSUE: begin
					state <= WAIT_BUSY;
				end
				WAIT_BUSY: begin
					if (busy) begin
						state <= WAIT_DONE;
					end
				end
				WAIT_DONE: begin
					if (!busy) begin
						if (last_entry) begin
							stage_done[stage] <= 1'b1;
							idx               <= '0;
							if (stage == 2'd2) begin
								state <= DONE;
							end else begin
								stage <= stage + 1'b1;
								state <= ISSUE;
							end
						end else begin
							idx   <= idx + 1'b1;
							state <= ISSUE;
						end
					end
				end
				DONE: begin
					state <= DONE;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// done bits fill from the bottom, one stage at a time
	a_stage_order: assert property (
		@(posedge clkcfg) disable iff (poweronreset)
		$changed(stage_done) |-> stage_done == (($past(stage_done) << 1) | 3'b001)
	);

endmodule

`default_nettype wire

/* i2c_cmd_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_cmd_arbiter import i2c_cfg_pkg::*; (
	input  logic       clkcfg,
	input  logic       poweronreset,
	input  i2c_cmd_t   board_cmd,
	input  logic       board_start,
	input  logic       board_done,
	input  i2c_cmd_t   fmc_cmd,
	input  logic       fmc_start,
	input  logic [2:0] fmc_done,
	input  i2c_cmd_t   host_cmd,
	input  logic       host_start,
	input  logic       host_mux_reset_b,
	input  i2c_rsp_t   rsp,
	output i2c_cmd_t   cmd,
	output logic       cmd_start,
	output init_done_t init_done,
	output logic       mux_reset_b,
	output i2c_rsp_t   host_rsp
);

	logic                  fmc_all_done;
	logic                  host_own;
	logic                  rsp_valid_q;
	logic [I2C_DWIDTH-1:0] rsp_data_q;

	assign fmc_all_done = &fmc_done;
	assign host_own     = board_done & fmc_all_done;

	// source follows init progress and the host comes after everything is up
	always_comb begin
		if (!board_done) begin
			cmd       = board_cmd;
			cmd_start = board_start;
		end else if (!fmc_all_done) begin
			cmd       = fmc_cmd;
			cmd_start = fmc_start;
		end else begin
			cmd       = host_cmd;
			cmd_start = host_start;
		end
	end

	assign init_done.board   = board_done;
	assign init_done.lmk_adc = fmc_done[0];
	assign init_done.dac     = fmc_done[1];
	assign init_done.dac2    = fmc_done[2];

	assign mux_reset_b = host_mux_reset_b | ~host_own;  // switch out of reset during init

	always_ff @(posedge clkcfg) begin
		if (poweronreset) begin
			rsp_valid_q <= 1'b0;
		end else begin
			rsp_valid_q <= rsp.rxvalid & host_own;
		end
	end

	always_ff @(posedge clkcfg) begin
		if (rsp.rxvalid && host_own) begin
			rsp_data_q <= rsp.rxdata;
		end
	end

	assign host_rsp = '{rxvalid: rsp_valid_q, rxdata: rsp_data_q};

	// init strobes only come from the sequencer that owns the engine
	a_board_owner: assert property (
		@(posedge clkcfg) disable iff (poweronreset)
		board_start |-> !board_done
	);

	a_fmc_owner: assert property (
		@(posedge clkcfg) disable iff (poweronreset)
		fmc_start |-> board_done && !fmc_all_done
	);

endmodule

`default_nettype wire

/* eeprom_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module eeprom_capture import i2c_cfg_pkg::*; (
	input  logic                   clkcfg,
	input  logic                   poweronreset,
	input  i2c_cmd_t               cmd,
	input  logic                   cmd_start,
	input  logic                   board_done,
	input  i2c_rsp_t               rsp,
	output logic [MACIP_WIDTH-1:0] mac_ip
);

	logic [7:0] last_addr;  // address byte of the command in flight
	logic [7:0] channel;    // current bus switch selection
	logic       capture;

	// read byte from the eeprom while the board table still runs
	assign capture = rsp.rxvalid && !board_done
		&& (channel == EEPROM_CHANNEL) && last_addr[0];

	always_ff @(posedge clkcfg) begin
		if (poweronreset) begin
			last_addr <= 8'h00;
			channel   <= 8'h00;
		end else if (cmd_start) begin
			last_addr <= cmd.data[31:24];
			if (cmd.data[31:24] == SW_ADDR_WR) begin
				channel <= cmd.data[23:16];
			end
		end
	end

	// first byte read ends up in the top of the word
	always_ff @(posedge clkcfg) begin
		if (poweronreset) begin
			mac_ip <= '0;
		end else if (capture) begin
			mac_ip <= {mac_ip[MACIP_WIDTH-9:0], rsp.rxdata[7:0]};
		end
	end

endmodule

`default_nettype wire

/* i2c_cfg_top.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_cfg_top import i2c_cfg_pkg::*; (
	input  logic                   clkcfg,
	input  logic                   poweronreset,
	output i2c_cmd_t               cmd,
	output logic                   cmd_start,
	input  logic                   busy,
	input  i2c_rsp_t               rsp,
	input  i2c_cmd_t               host_cmd,
	input  logic                   host_start,
	input  logic                   host_mux_reset_b,
	output i2c_rsp_t               host_rsp,
	output init_done_t             init_done,
	output logic                   mux_reset_b,
	output logic [MACIP_WIDTH-1:0] mac_ip
);

	i2c_cmd_t   board_cmd;
	logic       board_start;
	logic       board_done;
	i2c_cmd_t   fmc_cmd;
	logic       fmc_start;
	logic [2:0] fmc_done;

	board_init_seq board_init_seq_i (
		.clkcfg       (clkcfg),
		.poweronreset (poweronreset),
		.busy         (busy),
		.cmd          (board_cmd),
		.start        (board_start),
		.done         (board_done)
	);

	// front end starts once the board table is through
	fmc_init_seq fmc_init_seq_i (
		.clkcfg       (clkcfg),
		.poweronreset (poweronreset),
		.enable       (board_done),
		.busy         (busy),
		.cmd          (fmc_cmd),
		.start        (fmc_start),
		.stage_done   (fmc_done)
	);

	i2c_cmd_arbiter i2c_cmd_arbiter_i (
		.clkcfg           (clkcfg),
		.poweronreset     (poweronreset),
		.board_cmd        (board_cmd),
		.board_start      (board_start),
		.board_done       (board_done),
		.fmc_cmd          (fmc_cmd),
		.fmc_start        (fmc_start),
		.fmc_done         (fmc_done),
		.host_cmd         (host_cmd),
		.host_start       (host_start),
		.host_mux_reset_b (host_mux_reset_b),
		.rsp              (rsp),
		.cmd              (cmd),
		.cmd_start        (cmd_start),
		.init_done        (init_done),
		.mux_reset_b      (mux_reset_b),
		.host_rsp         (host_rsp)
	);

	// snoops the arbitrated command stream
	eeprom_capture eeprom_capture_i (
		.clkcfg       (clkcfg),
		.poweronreset (poweronreset),
		.cmd          (cmd),
		.cmd_start    (cmd_start),
		.board_done   (board_done),
		.rsp          (rsp),
		.mac_ip       (mac_ip)
	);

endmodule

`default_nettype wire

/* tb_i2c_cfg_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_i2c_cfg_top import i2c_cfg_pkg::*; ();

	localparam int VEC_DEPTH = 19;
	localparam int HOST_BASE = 13;  // first host command word

	logic                   clkcfg;
	logic                   poweronreset;
	i2c_cmd_t               cmd;
	logic                   cmd_start;
	logic                   busy;
	i2c_rsp_t               rsp;
	i2c_cmd_t               host_cmd;
	logic                   host_start;
	logic                   host_mux_reset_b;
	i2c_rsp_t               host_rsp;
	init_done_t             init_done;
	logic                   mux_reset_b;
	logic [MACIP_WIDTH-1:0] mac_ip;

	logic [39:0] vec [0:VEC_DEPTH-1];
	i2c_cmd_t    exp_q[$];   // commands expected on cmd in order
	logic [31:0] read_q[$];  // engine answers for read commands
	init_done_t  done_q;
	integer      seed;
	int          errors;
	int          host_n;

	i2c_cfg_top i2c_cfg_top_i (
		.clkcfg           (clkcfg),
		.poweronreset     (poweronreset),
		.cmd              (cmd),
		.cmd_start        (cmd_start),
		.busy             (busy),
		.rsp              (rsp),
		.host_cmd         (host_cmd),
		.host_start       (host_start),
		.host_mux_reset_b (host_mux_reset_b),
		.host_rsp         (host_rsp),
		.init_done        (init_done),
		.mux_reset_b      (mux_reset_b),
		.mac_ip           (mac_ip)
	);

	initial begin
		clkcfg = 1'b0;
		forever #4 clkcfg = ~clkcfg;
	end

	task automatic compare_value(input string name, input logic [79:0] got,
		input logic [79:0] exp);
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic finish_run();
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	endtask

	// runs one host command and waits for the engine and the read response
	task automatic run_host_cmd(input i2c_cmd_t c, input logic [31:0] resp);
		int   waited;
		logic saw_busy;
		logic saw_rsp;
		waited   = 0;
		saw_busy = 1'b0;
		saw_rsp  = 1'b0;
		@(negedge clkcfg);
		host_cmd   = c;
		host_start = 1'b1;
		@(negedge clkcfg);
		host_start = 1'b0;
		while (waited < 20 && !(saw_busy && !busy && (saw_rsp || !c.data[24]))) begin
			@(posedge clkcfg);
			waited++;
			if (busy) begin
				saw_busy = 1'b1;
			end
			if (host_rsp.rxvalid) begin
				saw_rsp = 1'b1;
				compare_value("host_rsp.rxdata", host_rsp.rxdata, resp);
			end
		end
		if (waited >= 20) begin
			errors++;
			$display("host command %h was not completed by the engine in time", c);
		end
	endtask

	// engine model raises busy for a random stretch then returns an optional read byte
	initial begin : engine
		int          hold;
		logic        is_read;
		busy = 1'b0;
		rsp  = '0;
		forever begin
			@(posedge clkcfg);
			if (!poweronreset && cmd_start) begin
				is_read = cmd.data[24];
				hold    = 2 + ($unsigned($random(seed)) % 8);
				@(negedge clkcfg);
				busy = 1'b1;
				repeat (hold) @(negedge clkcfg);
				busy = 1'b0;
				if (is_read) begin
					rsp.rxvalid = 1'b1;
					if (read_q.size() == 0) begin
						errors++;
						$display("engine got a read at %0t ns with no data left to return", $time);
						rsp.rxdata = '0;
					end else begin
						rsp.rxdata = read_q.pop_front();
					end
				end
				@(negedge clkcfg);
				rsp.rxvalid = 1'b0;
			end
		end
	end

	always @(posedge clkcfg) begin : monitor
		i2c_cmd_t exp_cmd;
		if (poweronreset) begin
			done_q <= '0;
		end else begin
			if (cmd_start) begin
				compare_value("busy at cmd_start", busy, 1'b0);
				if (exp_q.size() == 0) begin
					errors++;
					$display("unexpected cmd_start at %0t ns, no command left to expect", $time);
				end else begin
					exp_cmd = exp_q.pop_front();
					compare_value("cmd", cmd, exp_cmd);
				end
			end
			if (init_done != done_q) begin
				compare_value("init_done", init_done, {1'b1, done_q[3:1]});  // board first
			end
			done_q <= init_done;
			if (init_done != 4'hF) begin
				compare_value("mux_reset_b during init", mux_reset_b, 1'b1);
				compare_value("host_rsp.rxvalid during init", host_rsp.rxvalid, 1'b0);
			end
		end
	end

	// run limit from the number of commands
	initial begin : watchdog
		int cycles;
		int limit;
		cycles = 0;
		@(negedge poweronreset);
		limit = (BOARD_LEN + LMK_LEN + DAC_LEN + DAC2_LEN + host_n) * 12 + 200;
		while (cycles < limit) begin
			@(posedge clkcfg);
			cycles++;
		end
		errors++;
		$display("run did not finish within %0d cycles", limit);
		finish_run();
	end

	initial begin
		seed             = 32'h53b7;
		errors           = 0;
		poweronreset     = 1'b1;
		host_cmd         = '0;
		host_start       = 1'b0;
		host_mux_reset_b = 1'b0;  // must not reach mux_reset_b during init
		$readmemh("i2c_cfg_vectors.txt", vec);
		host_n = int'(vec[12]);
		for (int i = 0; i < 10; i++) read_q.push_back({24'h0, vec[i][7:0]});
		for (int i = 0; i < BOARD_LEN; i++) exp_q.push_back(BOARD_CMDS[i]);
		for (int i = 0; i < LMK_LEN; i++) exp_q.push_back(LMK_CMDS[i]);
		for (int i = 0; i < DAC_LEN; i++) exp_q.push_back(DAC_CMDS[i]);
		for (int i = 0; i < DAC2_LEN; i++) exp_q.push_back(DAC2_CMDS[i]);
		for (int k = 0; k < host_n; k++) begin
			exp_q.push_back(i2c_cmd_t'(vec[HOST_BASE + 2*k][36:0]));
			if (vec[HOST_BASE + 2*k][24]) begin
				read_q.push_back(vec[HOST_BASE + 2*k + 1][31:0]);
			end
		end

		repeat (8) @(negedge clkcfg);
		compare_value("cmd_start in reset", cmd_start, 1'b0);
		compare_value("host_rsp.rxvalid in reset", host_rsp.rxvalid, 1'b0);
		compare_value("init_done in reset", init_done, 4'h0);
		compare_value("mac_ip in reset", mac_ip, '0);
		compare_value("mux_reset_b in reset", mux_reset_b, 1'b1);
		poweronreset = 1'b0;

		// early host strobe while the engine is busy with the board table
		while (!busy) @(posedge clkcfg);
		@(negedge clkcfg);
		host_cmd   = i2c_cmd_t'(vec[HOST_BASE][36:0]);
		host_start = 1'b1;
		@(posedge clkcfg);
		compare_value("cmd_start on early host_start", cmd_start, 1'b0);
		@(negedge clkcfg);
		host_start = 1'b0;

		while (init_done != 4'hF) @(posedge clkcfg);
		@(negedge clkcfg);
		compare_value("init commands left", exp_q.size(), host_n);
		compare_value("mac_ip", mac_ip, {vec[10], vec[11]});

		host_mux_reset_b = 1'b0;
		@(posedge clkcfg);
		compare_value("mux_reset_b after init", mux_reset_b, 1'b0);
		@(negedge clkcfg);
		host_mux_reset_b = 1'b1;
		@(posedge clkcfg);
		compare_value("mux_reset_b after init", mux_reset_b, 1'b1);

		for (int k = 0; k < host_n; k++) begin
			run_host_cmd(i2c_cmd_t'(vec[HOST_BASE + 2*k][36:0]), vec[HOST_BASE + 2*k + 1][31:0]);
		end
		repeat (4) @(negedge clkcfg);
		compare_value("host commands left", exp_q.size(), 0);
		compare_value("mac_ip after host reads", mac_ip, {vec[10], vec[11]});
		finish_run();
	end

endmodule

`default_nettype wire

/* i2c_cfg_vectors.txt */
// words 0-9: eeprom bytes returned on channel 8, in read order
// words 10-11: expected mac_ip, upper then lower 40 bits
// word 12: number of host commands, then pairs of 37-bit command and read data
02
0A
35
11
22
33
C0
A8
01
0A
020A351122
33C0A8010A
3
145C020082
0
115D000000
C3
12A1000000
5A3C

/* sources.f */
i2c_cfg_pkg.sv
board_init_seq.sv
fmc_init_seq.sv
i2c_cmd_arbiter.sv
eeprom_capture.sv
i2c_cfg_top.sv
tb_i2c_cfg_top.sv

/* Bender.yml */
package:
  name: i2c_cfg

sources:
  - i2c_cfg_pkg.sv
  - board_init_seq.sv
  - fmc_init_seq.sv
  - i2c_cmd_arbiter.sv
  - eeprom_capture.sv
  - i2c_cfg_top.sv
  - target: test
    files:
      - tb_i2c_cfg_top.sv
